// ==== npc_top.f ====
+incdir+src
src/axi_pkg.sv
src/npc_pkg.sv
src/npc_axi_master.sv
src/npc_ram.sv
src/npc_top.sv
sim/npc_top_sva.sv
sim/npc_top_tb.sv

// ==== Makefile ====
TB_TOP := npc_top_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f npc_top.f --top-module $(TB_TOP)
	verilator --lint-only -f npc_top.f src/npc_top.sv --top-module npc_top

sim:
	verilator --binary --timing --assert -f npc_top.f --top-module $(TB_TOP) \
		-o $(TB_TOP)_sim
	./obj_dir/$(TB_TOP)_sim | tee /dev/stderr | grep "Everything OK" > /dev/null

clean:
	rm -rf obj_dir

// ==== sim/npc_top_tb.sv ====
`timescale 1ns/1ps
`include "npc_defines.svh"

module npc_top_tb;

  // ops per test in order of the tests below
  localparam int N_OPS = 2 + 20 * 2 + 20 * 3 + 5 * (`NPC_LINE_WORDS + 1) + 5 + 5 * 3;
  // worst cycles per op including the idle wait
  localparam int WORST_LAT = 16;
  localparam int CYCLE_LIMIT = N_OPS * WORST_LAT + `NPC_TIMEOUT_SLACK + 8;
  localparam int RAM_BYTES = 4 * `NPC_RAM_WORDS;

  logic clock;
  logic arst_n;
  logic fetch_req;
  logic lsu_req;
  axi_pkg::addr_t fetch_addr;
  npc_pkg::lsu_cmd_t lsu_cmd;
  logic fetch_busy;
  logic lsu_busy;
  npc_pkg::fetch_rsp_t fetch_rsp;
  npc_pkg::lsu_rsp_t lsu_rsp;

  // shadow of the ram contents
  axi_pkg::data_t shadow [`NPC_RAM_WORDS];
  logic [31:0] lfsr;
  int cycles;
  int errors;
  int checks;
  int test_errors;
  int test_checks;

  // expected responses in arrival order
  npc_pkg::lsu_rsp_t exp_lsu_q[$];
  bit exp_data_q[$];
  int exp_lat_q[$];
  int issue_q[$];
  npc_pkg::fetch_rsp_t exp_fetch_q[$];

  npc_top i_dut (
    .clock(clock), .arst_n(arst_n), .fetch_req(fetch_req), .fetch_addr(fetch_addr),
    .lsu_req(lsu_req), .lsu_cmd(lsu_cmd), .fetch_busy(fetch_busy), .lsu_busy(lsu_busy),
    .fetch_rsp(fetch_rsp), .lsu_rsp(lsu_rsp)
  );

  always #20 clock = ~clock;

  // galois lfsr stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic axi_pkg::data_t merge_bytes(input axi_pkg::data_t old_w,
                                                 input axi_pkg::data_t new_w,
                                                 input axi_pkg::strb_t strb);
    axi_pkg::data_t m;
    m = old_w;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) m[8*i +: 8] = new_w[8*i +: 8];
    end
    return m;
  endfunction

  // err from the range rule and rdata only for in-range loads
  function automatic npc_pkg::lsu_rsp_t ref_lsu(input npc_pkg::lsu_cmd_t cmd);
    npc_pkg::lsu_rsp_t rsp;
    rsp.valid = 1'b1;
    rsp.err = (cmd.addr >= RAM_BYTES);
    rsp.rdata = '0;
    if (!rsp.err && cmd.op == npc_pkg::LSU_LOAD) rsp.rdata = shadow[cmd.addr[11:2]];
    return rsp;
  endfunction

  function automatic npc_pkg::fetch_rsp_t ref_fetch(input axi_pkg::addr_t addr, input int beat);
    npc_pkg::fetch_rsp_t rsp;
    axi_pkg::addr_t a;
    a = (addr & ~axi_pkg::addr_t'(`NPC_LINE_WORDS * 4 - 1)) + 4 * beat;
    rsp.valid = 1'b1;
    rsp.last = (beat == `NPC_LINE_WORDS - 1);
    rsp.err = (a >= RAM_BYTES);
    rsp.data = rsp.err ? '0 : shadow[a[11:2]];
    return rsp;
  endfunction

  task automatic report_error(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    errors++;
    test_errors++;
  endtask

  task automatic compare_lsu(input npc_pkg::lsu_rsp_t got, input npc_pkg::lsu_rsp_t exp,
                             input bit check_data);
    checks++;
    test_checks++;
    if (got.err !== exp.err) report_error($sformatf("lsu err %b, expected %b", got.err, exp.err));
    if (check_data && got.rdata !== exp.rdata)
      report_error($sformatf("lsu rdata %h, expected %h", got.rdata, exp.rdata));
  endtask

  task automatic compare_fetch(input npc_pkg::fetch_rsp_t got, input npc_pkg::fetch_rsp_t exp);
    checks++;
    test_checks++;
    if (got.last !== exp.last || got.err !== exp.err || got.data !== exp.data)
      report_error($sformatf("fetch beat last %b err %b data %h, expected %b %b %h",
                             got.last, got.err, got.data, exp.last, exp.err, exp.data));
  endtask

  // compare process and cycle limit
  always @(posedge clock) begin
    int lat;
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout: run took more than %0d cycles", CYCLE_LIMIT);
      $display("Something failed");
      $finish;
    end
    if (lsu_rsp.valid === 1'b1) begin
      if (exp_lsu_q.size() == 0) begin
        report_error("lsu response with none expected");
      end else begin
        compare_lsu(lsu_rsp, exp_lsu_q.pop_front(), exp_data_q.pop_front());
        lat = cycles - issue_q.pop_front();
        if (exp_lat_q[0] > 0 && lat != exp_lat_q[0])
          report_error($sformatf("lsu latency %0d, expected %0d", lat, exp_lat_q[0]));
        void'(exp_lat_q.pop_front());
      end
    end
    if (fetch_rsp.valid === 1'b1) begin
      if (exp_fetch_q.size() == 0) report_error("fetch beat with none expected");
      else compare_fetch(fetch_rsp, exp_fetch_q.pop_front());
    end
  end

  task automatic wait_idle();
    while (lsu_busy || fetch_busy) @(negedge clock);
  endtask

  // one strobe cycle from a falling edge to the next
  task automatic issue_lsu(input npc_pkg::lsu_op_t op, input axi_pkg::addr_t addr,
                           input axi_pkg::data_t data, input axi_pkg::strb_t strb,
                           input int lat);
    npc_pkg::lsu_cmd_t cmd;
    cmd = '{op: op, addr: addr, wdata: data, wstrb: strb};
    exp_lsu_q.push_back(ref_lsu(cmd));
    exp_data_q.push_back(op == npc_pkg::LSU_LOAD);
    exp_lat_q.push_back(lat);
    issue_q.push_back(cycles);
    if (op == npc_pkg::LSU_STORE && addr < RAM_BYTES)
      shadow[addr[11:2]] = merge_bytes(shadow[addr[11:2]], data, strb);
    lsu_req = 1'b1;
    lsu_cmd = cmd;
    @(negedge clock);
    lsu_req = 1'b0;
  endtask

  // called on a falling edge with the bus idle
  task automatic do_lsu(input npc_pkg::lsu_op_t op, input axi_pkg::addr_t addr,
                        input axi_pkg::data_t data, input axi_pkg::strb_t strb, input int lat);
    issue_lsu(op, addr, data, strb, lat);
    wait_idle();
  endtask

  task automatic do_fetch(input axi_pkg::addr_t addr);
    for (int i = 0; i < `NPC_LINE_WORDS; i++) exp_fetch_q.push_back(ref_fetch(addr, i));
    fetch_req = 1'b1;
    fetch_addr = addr;
    @(negedge clock);
    fetch_req = 1'b0;
    wait_idle();
  endtask

  task automatic end_test(input string name);
    while (exp_lsu_q.size() != 0 || exp_fetch_q.size() != 0) @(negedge clock);
    $display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
    test_checks = 0;
    test_errors = 0;
  endtask

  initial begin
    axi_pkg::addr_t a;
    axi_pkg::data_t d;
    clock = 1'b0;
    arst_n = 1'b0;
    fetch_req = 1'b0;
    lsu_req = 1'b0;
    fetch_addr = '0;
    lsu_cmd = '0;
    lfsr = 32'hb08925b3;
    cycles = 0;
    errors = 0;
    checks = 0;
    test_errors = 0;
    test_checks = 0;
    // outputs stay low through reset and just after
    for (int i = 0; i < 9; i++) begin
      @(negedge clock);
      if (i == 7) arst_n = 1'b1;
      checks++;
      test_checks++;
      if ({fetch_busy, lsu_busy, fetch_rsp.valid, lsu_rsp.valid} !== 4'b0000)
        report_error("busy or response valid not low around reset");
    end
    a = rand_bits(10) << 2;
    do_lsu(npc_pkg::LSU_STORE, a, rand_bits(32), 4'hf, 5);
    do_lsu(npc_pkg::LSU_LOAD, a, '0, '0, 4);
    end_test("reset_and_latency");

    for (int i = 0; i < 20; i++) begin
      a = rand_bits(10) << 2;
      do_lsu(npc_pkg::LSU_STORE, a, rand_bits(32), 4'hf, 0);
      do_lsu(npc_pkg::LSU_LOAD, a, '0, '0, 0);
    end
    end_test("store_load");

    for (int i = 0; i < 20; i++) begin
      a = rand_bits(10) << 2;
      do_lsu(npc_pkg::LSU_STORE, a, rand_bits(32), 4'hf, 0);
      do_lsu(npc_pkg::LSU_STORE, a, rand_bits(32), axi_pkg::strb_t'(rand_bits(4)), 0);
      do_lsu(npc_pkg::LSU_LOAD, a, '0, '0, 0);
    end
    end_test("partial_strobe");

    for (int i = 0; i < 5; i++) begin
      a = rand_bits(8) << 4;
      for (int k = 0; k < `NPC_LINE_WORDS; k++)
        do_lsu(npc_pkg::LSU_STORE, a + 4 * k, rand_bits(32), 4'hf, 0);
      do_fetch(a | rand_bits(4));
    end
    end_test("line_fetch");

    // out of range store aliases the in-range word if not guarded
    a = rand_bits(10) << 2;
    do_lsu(npc_pkg::LSU_STORE, a, rand_bits(32), 4'hf, 0);
    do_lsu(npc_pkg::LSU_STORE, a + RAM_BYTES, rand_bits(32), 4'hf, 0);
    do_lsu(npc_pkg::LSU_LOAD, a + RAM_BYTES, '0, '0, 0);
    do_fetch(a + RAM_BYTES);
    do_lsu(npc_pkg::LSU_LOAD, a, '0, '0, 0);
    end_test("out_of_range");

    for (int i = 0; i < 5; i++) begin
      a = rand_bits(8) << 4;
      d = rand_bits(32);
      do_lsu(npc_pkg::LSU_STORE, a, d, 4'hf, 0);
      // both strobes in one idle cycle, load/store owns the bus
      fetch_req = 1'b1;
      fetch_addr = a;
      issue_lsu(npc_pkg::LSU_LOAD, a, '0, '0, 4);
      fetch_req = 1'b0;
      checks++;
      test_checks++;
      if (lsu_busy !== 1'b1 || fetch_busy !== 1'b0)
        report_error($sformatf("after joint strobe lsu_busy %b fetch_busy %b, expected 1 0",
                               lsu_busy, fetch_busy));
      wait_idle();
      do_fetch(a);
    end
    end_test("contention");

    $display("total: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== sim/npc_top_sva.sv ====
`timescale 1ns/1ps
`include "npc_defines.svh"

module npc_top_sva (
  input logic             clock,
  input logic             arst_n,
  input axi_pkg::axi_ar_t ar,
  input axi_pkg::axi_aw_t aw,
  input axi_pkg::axi_w_t  w,
  input axi_pkg::axi_r_t  r,
  input axi_pkg::axi_b_t  b,
  input logic             arready,
  input logic             awready,
  input logic             wready,
  input logic             rready,
  input logic             bready
);

  logic         fetch_beat;
  logic [7:0]   beat_cnt;
  axi_pkg::id_t ar_id_q;
  axi_pkg::id_t aw_id_q;

  assign fetch_beat = r.valid && rready && (r.id == axi_pkg::id_t'(`NPC_ID_FETCH));

  // beats seen so far in the current fetch burst
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      beat_cnt <= '0;
    end else if (fetch_beat) begin
      beat_cnt <= r.last ? '0 : beat_cnt + 1'b1;
    end
  end

  // ids of the open transfers
  always_ff @(posedge clock) begin
    if (ar.valid && arready) ar_id_q <= ar.id;
    if (aw.valid && awready) aw_id_q <= aw.id;
  end

  // payload held until handshake
  a_ar_stable: assert property (@(posedge clock) disable iff (!arst_n)
    ar.valid && !arready |=> ar.valid && $stable(ar)) else $error("ar changed before arready");
  a_aw_stable: assert property (@(posedge clock) disable iff (!arst_n)
    aw.valid && !awready |=> aw.valid && $stable(aw)) else $error("aw changed before awready");
  a_w_stable: assert property (@(posedge clock) disable iff (!arst_n)
    w.valid && !wready |=> w.valid && $stable(w)) else $error("w changed before wready");
  a_r_stable: assert property (@(posedge clock) disable iff (!arst_n)
    r.valid && !rready |=> r.valid && $stable(r)) else $error("r changed before rready");
  a_b_stable: assert property (@(posedge clock) disable iff (!arst_n)
    b.valid && !bready |=> b.valid && $stable(b)) else $error("b changed before bready");

  a_no_x: assert property (@(posedge clock) disable iff (!arst_n)
    !$isunknown({ar.valid, aw.valid, w.valid, r.valid, b.valid})) else $error("valid is X");

  // rlast exactly on the final line beat
  a_fetch_last: assert property (@(posedge clock) disable iff (!arst_n)
    fetch_beat |-> (r.last == (beat_cnt == 8'(`NPC_LINE_WORDS - 1))))
    else $error("rlast misplaced in fetch burst");

  a_r_id: assert property (@(posedge clock) disable iff (!arst_n)
    r.valid |-> (r.id == ar_id_q)) else $error("rid does not match arid");
  a_b_id: assert property (@(posedge clock) disable iff (!arst_n)
    b.valid |-> (b.id == aw_id_q)) else $error("bid does not match awid");

endmodule

bind npc_top npc_top_sva i_sva (
  .clock(clock), .arst_n(arst_n), .ar(ar), .aw(aw), .w(w), .r(r), .b(b),
  .arready(arready), .awready(awready), .wready(wready), .rready(rready), .bready(bready)
);

// ==== src/npc_top.sv ====
`timescale 1ns/1ps

module npc_top (
  input  logic                clock,
  input  logic                arst_n,
  input  logic                fetch_req,
  input  axi_pkg::addr_t      fetch_addr,
  input  logic                lsu_req,
  input  npc_pkg::lsu_cmd_t   lsu_cmd,
  output logic                fetch_busy,
  output logic                lsu_busy,
  output npc_pkg::fetch_rsp_t fetch_rsp,
  output npc_pkg::lsu_rsp_t   lsu_rsp
);

  // master to ram
  axi_pkg::axi_ar_t ar;
  axi_pkg::axi_aw_t aw;
  axi_pkg::axi_w_t  w;
  logic             rready;
  logic             bready;

  // ram to master
  axi_pkg::axi_r_t  r;
  axi_pkg::axi_b_t  b;
  logic             arready;
  logic             awready;
  logic             wready;

  // bus unit, both clients share one axi master
  npc_axi_master i_master (
    .clock      (clock),
    .arst_n     (arst_n),
    .fetch_req  (fetch_req),
    .fetch_addr (fetch_addr),
    .lsu_req    (lsu_req),
    .lsu_cmd    (lsu_cmd),
    .fetch_busy (fetch_busy),
    .lsu_busy   (lsu_busy),
    .fetch_rsp  (fetch_rsp),
    .lsu_rsp    (lsu_rsp),
    .ar         (ar),
    .aw         (aw),
    .w          (w),
    .rready     (rready),
    .bready     (bready),
    .arready    (arready),
    .awready    (awready),
    .wready     (wready),
    .r          (r),
    .b          (b)
  );

  // simulation memory on the same bus
  npc_ram i_ram (
    .clock   (clock),
    .arst_n  (arst_n),
    .ar      (ar),
    .aw      (aw),
    .w       (w),
    .rready  (rready),
    .bready  (bready),
    .arready (arready),
    .awready (awready),
    .wready  (wready),
    .r       (r),
    .b       (b)
  );

endmodule

// ==== src/npc_ram.sv ====
`timescale 1ns/1ps
`include "npc_defines.svh"

module npc_ram (
  input  logic             clock,
  input  logic             arst_n,
  input  axi_pkg::axi_ar_t ar,
  input  axi_pkg::axi_aw_t aw,
  input  axi_pkg::axi_w_t  w,
  input  logic             rready,
  input  logic             bready,
  output logic             arready,
  output logic             awready,
  output logic             wready,
  output axi_pkg::axi_r_t  r,
  output axi_pkg::axi_b_t  b
);

  localparam int IDX_W = $clog2(`NPC_RAM_WORDS);
  localparam int LANES = $bits(axi_pkg::strb_t);

  // word storage
  axi_pkg::data_t mem [`NPC_RAM_WORDS];

  npc_pkg::ram_state_t state;

  // read burst, address of next beat and beats left after current
  axi_pkg::addr_t rd_addr;
  axi_pkg::addr_t rd_step;
  axi_pkg::len_t  rd_cnt;
  axi_pkg::addr_t rd_sel;

  logic           r_valid;
  logic           r_last;
  axi_pkg::id_t   r_id;
  axi_pkg::data_t r_data;
  axi_pkg::resp_t r_resp;

  // write burst
  axi_pkg::addr_t wr_addr;
  axi_pkg::addr_t wr_step;
  axi_pkg::len_t  wr_cnt;
  axi_pkg::id_t   wr_id;
  logic           wr_err;
  logic           wr_end;

  logic           b_valid;
  axi_pkg::id_t   b_id;
  axi_pkg::resp_t b_resp;

  logic ar_fire;
  logic r_fire;
  logic aw_fire;
  logic w_fire;
  logic b_fire;

  function automatic logic in_range(input axi_pkg::addr_t a);
    return a < axi_pkg::addr_t'(4 * `NPC_RAM_WORDS);
  endfunction

  // address increment per beat, none for fixed bursts
  function automatic axi_pkg::addr_t beat_step(input axi_pkg::size_t size,
                                               input axi_pkg::burst_t burst);
    return (burst == axi_pkg::BURST_FIXED) ? '0 : (axi_pkg::addr_t'(1) << size);
  endfunction

  assign arready = (state == npc_pkg::RAM_IDLE);
  // a read waiting in idle goes first
  assign awready = (state == npc_pkg::RAM_IDLE) && !ar.valid;
  assign wready  = (state == npc_pkg::RAM_WRITE);

  assign ar_fire = ar.valid && arready;
  assign r_fire  = r_valid && rready;
  assign aw_fire = aw.valid && awready;
  assign w_fire  = w.valid && wready;
  assign b_fire  = b_valid && bready;
  assign wr_end  = (wr_cnt == '0);

  // first beat addressed by ar, later beats by the running address
  assign rd_sel = ar_fire ? ar.addr : rd_addr;

  assign r = '{id: r_id, data: r_data, resp: r_resp, last: r_last, valid: r_valid};
  assign b = '{id: b_id, resp: b_resp, valid: b_valid};

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state   <= npc_pkg::RAM_IDLE;
      r_valid <= 1'b0;
      b_valid <= 1'b0;
      rd_cnt  <= '0;
      wr_cnt  <= '0;
    end else begin
      case (state)
        npc_pkg::RAM_IDLE: begin
          if (ar_fire) begin
            state   <= npc_pkg::RAM_READ;
            r_valid <= 1'b1;
            rd_cnt  <= ar.len;
          end else if (aw_fire) begin
            state  <= npc_pkg::RAM_WRITE;
            wr_cnt <= aw.len;
          end
        end
        npc_pkg::RAM_READ: begin
          // beat held until rready
          if (r_fire && r_last) begin
            r_valid <= 1'b0;
            state   <= npc_pkg::RAM_IDLE;
          end else if (r_fire) begin
            rd_cnt <= rd_cnt - 1'b1;
          end
        end
        npc_pkg::RAM_WRITE: begin
          if (w_fire && wr_end) begin
            b_valid <= 1'b1;
            state   <= npc_pkg::RAM_RESP;
          end else if (w_fire) begin
            wr_cnt <= wr_cnt - 1'b1;
          end
        end
        npc_pkg::RAM_RESP: begin
          if (b_fire) begin
            b_valid <= 1'b0;
            state   <= npc_pkg::RAM_IDLE;
          end
        end
        default: state <= npc_pkg::RAM_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    // load next read beat on ar or on a non-final r handshake
    if (ar_fire || (r_fire && !r_last)) begin
      r_data  <= in_range(rd_sel) ? mem[rd_sel[IDX_W+1:2]] : '0;
      r_resp  <= in_range(rd_sel) ? axi_pkg::RESP_OKAY : axi_pkg::RESP_SLVERR;
      rd_addr <= rd_sel + (ar_fire ? beat_step(ar.size, ar.burst) : rd_step);
    end
    if (ar_fire) begin
      r_id    <= ar.id;
      r_last  <= (ar.len == '0);
      rd_step <= beat_step(ar.size, ar.burst);
    end else if (r_fire && !r_last) begin
      r_last <= (rd_cnt == axi_pkg::len_t'(1));
    end
    if (aw_fire) begin
      wr_addr <= aw.addr;
      wr_step <= beat_step(aw.size, aw.burst);
      wr_id   <= aw.id;
      wr_err  <= 1'b0;
    end
    if (w_fire) begin
      // out of range beats leave memory alone
      if (in_range(wr_addr)) begin
        for (int i = 0; i < LANES; i++) begin
          if (w.strb[i]) mem[wr_addr[IDX_W+1:2]][8*i +: 8] <= w.data[8*i +: 8];
        end
      end
      wr_addr <= wr_addr + wr_step;
      // wlast off the expected beat also counts as an error
      if (wr_end) begin
        b_id   <= wr_id;
        b_resp <= (wr_err || !in_range(wr_addr) || !w.last) ? axi_pkg::RESP_SLVERR :
                                                              axi_pkg::RESP_OKAY;
      end else if (!in_range(wr_addr) || w.last) begin
        wr_err <= 1'b1;
      end
    end
  end

endmodule

// ==== src/npc_axi_master.sv ====
`timescale 1ns/1ps
`include "npc_defines.svh"

module npc_axi_master (
  input  logic                clock,
  input  logic                arst_n,
  input  logic                fetch_req,
  input  axi_pkg::addr_t      fetch_addr,
  input  logic                lsu_req,
  input  npc_pkg::lsu_cmd_t   lsu_cmd,
  output logic                fetch_busy,
  output logic                lsu_busy,
  output npc_pkg::fetch_rsp_t fetch_rsp,
  output npc_pkg::lsu_rsp_t   lsu_rsp,
  output axi_pkg::axi_ar_t    ar,
  output axi_pkg::axi_aw_t    aw,
  output axi_pkg::axi_w_t     w,
  output logic                rready,
  output logic                bready,
  input  logic                arready,
  input  logic                awready,
  input  logic                wready,
  input  axi_pkg::axi_r_t     r,
  input  axi_pkg::axi_b_t     b
);

  localparam axi_pkg::id_t   ID_FETCH  = axi_pkg::id_t'(`NPC_ID_FETCH);
  localparam axi_pkg::id_t   ID_LSU    = axi_pkg::id_t'(`NPC_ID_LSU);
  localparam axi_pkg::len_t  LINE_LEN  = axi_pkg::len_t'(`NPC_LINE_WORDS - 1);
  // low address bits dropped for a line and for a word
  localparam axi_pkg::addr_t LINE_MASK = axi_pkg::addr_t'(`NPC_LINE_WORDS * 4 - 1);
  localparam axi_pkg::addr_t WORD_MASK = axi_pkg::addr_t'(3);

  npc_pkg::bus_state_t state;
  // W already accepted while AW still waits
  logic w_done;

  // request owning the bus
  axi_pkg::id_t   req_id;
  axi_pkg::addr_t req_addr;
  axi_pkg::len_t  req_len;
  axi_pkg::data_t req_wdata;
  axi_pkg::strb_t req_wstrb;

  // registered client responses
  logic           fetch_valid;
  logic           fetch_last;
  logic           fetch_err;
  axi_pkg::data_t fetch_data;
  logic           lsu_valid;
  logic           lsu_err;
  axi_pkg::data_t lsu_rdata;

  logic lsu_take;
  logic fetch_take;
  logic ar_fire;
  logic aw_fire;
  logic w_fire;
  logic r_fetch;
  logic r_lsu;
  logic b_lsu;

  // strobes only taken in idle, load/store first
  // a strobe that does not raise busy must be repeated
  assign lsu_take   = (state == npc_pkg::BUS_IDLE) && lsu_req;
  assign fetch_take = (state == npc_pkg::BUS_IDLE) && !lsu_req && fetch_req;

  // valids come straight from state, payload from latched request
  assign ar = '{id: req_id, addr: req_addr, len: req_len, size: axi_pkg::SIZE_4B,
                burst: axi_pkg::BURST_INCR, valid: (state == npc_pkg::BUS_RD_ADDR)};
  assign aw = '{id: req_id, addr: req_addr, len: req_len, size: axi_pkg::SIZE_4B,
                burst: axi_pkg::BURST_INCR, valid: (state == npc_pkg::BUS_WR_ADDR)};
  // single beat writes, W raised together with AW
  assign w  = '{data: req_wdata, strb: req_wstrb, last: 1'b1,
                valid: ((state == npc_pkg::BUS_WR_ADDR) && !w_done) ||
                       (state == npc_pkg::BUS_WR_DATA)};

  // ready for responses for as long as a transfer is open
  assign rready = (state == npc_pkg::BUS_RD_ADDR) || (state == npc_pkg::BUS_RD_DATA);
  assign bready = (state == npc_pkg::BUS_WR_ADDR) || (state == npc_pkg::BUS_WR_DATA) ||
                  (state == npc_pkg::BUS_WR_RESP);

  assign ar_fire = ar.valid && arready;
  assign aw_fire = aw.valid && awready;
  assign w_fire  = w.valid && wready;
  // response steering by id
  assign r_fetch = r.valid && rready && (r.id == ID_FETCH);
  assign r_lsu   = r.valid && rready && (r.id == ID_LSU);
  assign b_lsu   = b.valid && bready && (b.id == ID_LSU);

  assign fetch_rsp = '{valid: fetch_valid, last: fetch_last, err: fetch_err, data: fetch_data};
  assign lsu_rsp   = '{valid: lsu_valid, err: lsu_err, rdata: lsu_rdata};

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state       <= npc_pkg::BUS_IDLE;
      w_done      <= 1'b0;
      fetch_busy  <= 1'b0;
      lsu_busy    <= 1'b0;
      fetch_valid <= 1'b0;
      lsu_valid   <= 1'b0;
    end else begin
      case (state)
        npc_pkg::BUS_IDLE: begin
          w_done <= 1'b0;
          if (lsu_take) begin
            lsu_busy <= 1'b1;
            state    <= (lsu_cmd.op == npc_pkg::LSU_STORE) ? npc_pkg::BUS_WR_ADDR :
                                                             npc_pkg::BUS_RD_ADDR;
          end else if (fetch_take) begin
            fetch_busy <= 1'b1;
            state      <= npc_pkg::BUS_RD_ADDR;
          end
        end
        npc_pkg::BUS_RD_ADDR: if (ar_fire) state <= npc_pkg::BUS_RD_DATA;
        npc_pkg::BUS_RD_DATA: if ((r_fetch || r_lsu) && r.last) state <= npc_pkg::BUS_IDLE;
        npc_pkg::BUS_WR_ADDR: begin
          if (aw_fire) begin
            state <= (w_fire || w_done) ? npc_pkg::BUS_WR_RESP : npc_pkg::BUS_WR_DATA;
          end else if (w_fire) begin
            w_done <= 1'b1;
          end
        end
        npc_pkg::BUS_WR_DATA: if (w_fire) state <= npc_pkg::BUS_WR_RESP;
        npc_pkg::BUS_WR_RESP: if (b_lsu) state <= npc_pkg::BUS_IDLE;
        default: state <= npc_pkg::BUS_IDLE;
      endcase
      // one pulse per beat
      fetch_valid <= r_fetch;
      lsu_valid   <= r_lsu || b_lsu;
      // busy drops with the final response beat
      if (r_fetch && r.last) fetch_busy <= 1'b0;
      if ((r_lsu && r.last) || b_lsu) lsu_busy <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (lsu_take) begin
      req_id    <= ID_LSU;
      req_addr  <= lsu_cmd.addr & ~WORD_MASK;
      req_len   <= '0;
      req_wdata <= lsu_cmd.wdata;
      req_wstrb <= lsu_cmd.wstrb;
    end else if (fetch_take) begin
      // line aligned
      req_id    <= ID_FETCH;
      req_addr  <= fetch_addr & ~LINE_MASK;
      req_len   <= LINE_LEN;
      req_wstrb <= '0;
    end
    if (r_fetch) begin
      fetch_last <= r.last;
      fetch_err  <= (r.resp == axi_pkg::RESP_SLVERR);
      fetch_data <= r.data;
    end
    if (r_lsu) begin
      lsu_err   <= (r.resp == axi_pkg::RESP_SLVERR);
      lsu_rdata <= r.data;
    end else if (b_lsu) begin
      lsu_err <= (b.resp == axi_pkg::RESP_SLVERR);
    end
  end

endmodule

// ==== src/npc_pkg.sv ====
package npc_pkg;

  typedef enum logic {
    LSU_LOAD,
    LSU_STORE
  } lsu_op_t;

  // one load/store access as handed over with the strobe
  typedef struct packed {
    lsu_op_t        op;
    axi_pkg::addr_t addr;
    axi_pkg::data_t wdata;
    axi_pkg::strb_t wstrb;
  } lsu_cmd_t;

  // rdata only meaningful for loads
  typedef struct packed {
    logic           valid;
    logic           err;
    axi_pkg::data_t rdata;
  } lsu_rsp_t;

  // one beat of a line fetch
  typedef struct packed {
    logic           valid;
    logic           last;
    logic           err;
    axi_pkg::data_t data;
  } fetch_rsp_t;

  typedef enum logic [2:0] {
    BUS_IDLE,
    BUS_RD_ADDR,
    BUS_RD_DATA,
    BUS_WR_ADDR,
    BUS_WR_DATA,
    BUS_WR_RESP
  } bus_state_t;

  typedef enum logic [1:0] {
    RAM_IDLE,
    RAM_READ,
    RAM_WRITE,
    RAM_RESP
  } ram_state_t;

endpackage

// ==== src/axi_pkg.sv ====
package axi_pkg;

  // byte address and bus word
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  // one enable per byte lane
  typedef logic [3:0]  strb_t;
  typedef logic [3:0]  id_t;
  // beats minus one
  typedef logic [7:0]  len_t;
  typedef logic [2:0]  size_t;
  typedef logic [1:0]  burst_t;
  typedef logic [1:0]  resp_t;

  // 4 bytes per beat
  localparam size_t  SIZE_4B     = 3'd2;
  localparam burst_t BURST_FIXED = 2'd0;
  localparam burst_t BURST_INCR  = 2'd1;
  localparam resp_t  RESP_OKAY   = 2'd0;
  localparam resp_t  RESP_SLVERR = 2'd2;

  // read address, master to slave
  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
    logic   valid;
  } axi_ar_t;

  // write address carries the same fields
  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
    logic   valid;
  } axi_aw_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
    logic  valid;
  } axi_w_t;

  // read data, slave to master
  typedef struct packed {
    id_t   id;
    data_t data;
    resp_t resp;
    logic  last;
    logic  valid;
  } axi_r_t;

  typedef struct packed {
    id_t   id;
    resp_t resp;
    logic  valid;
  } axi_b_t;

endpackage

// ==== src/npc_defines.svh ====
`ifndef NPC_DEFINES_SVH
`define NPC_DEFINES_SVH

// ram depth in 32-bit words
// byte addresses from 4x this value upward are out of range
`define NPC_RAM_WORDS 1024

// beats per instruction fetch burst
`define NPC_LINE_WORDS 4

// axi transaction ids, one per client
`define NPC_ID_FETCH 0
`define NPC_ID_LSU 1

// spare cycles added on top of the expected run length
// before a hung simulation is stopped
`define NPC_TIMEOUT_SLACK 200

`endif
